/* verilog/xbus_pkg.sv */
// xbus shared definitions
package xbus_pkg;

   parameter int xbus_addr_w = 22;
   parameter int xbus_data_w = 32;

   // one queued bus command
   typedef struct packed {
      logic [xbus_addr_w-1:0] addr;
      logic [xbus_data_w-1:0] data;
      logic                   write;   // high for a write
   } xbus_req_t;

   // low address bits covered by each window
   parameter int unibus_win_bits = 6;
   parameter int spy_win_bits    = 6;
   parameter int lashup_win_bits = 12;

   // window bases, octal
   parameter logic [xbus_addr_w-1:0] unibus_base = 22'o17773000;
   parameter logic [xbus_addr_w-1:0] spy_base    = 22'o17777700;
   parameter logic [xbus_addr_w-1:0] lashup_base = 22'o17740000;

   // timeout address ranges for the nxm flags
   parameter logic [xbus_addr_w-1:0] unibus_nxm_floor = 22'o17400000;
   parameter logic [xbus_addr_w-1:0] xbus_nxm_floor   = 22'o17000000;

   // register offsets inside the unibus window
   parameter logic [unibus_win_bits-1:0] reg_prom   = 6'o05;
   parameter logic [unibus_win_bits-1:0] reg_ints   = 6'o20;
   parameter logic [unibus_win_bits-1:0] reg_status = 6'o22;

   parameter int ints_en_bit    = 10;
   parameter int unibus_nxm_bit = 3;
   parameter int xbus_nxm_bit   = 0;

endpackage

/* verilog/xbus_if.sv */
// xbus master to device link
interface xbus_if
   import xbus_pkg::*;
   (input logic clk);

   logic [xbus_addr_w-1:0] addr;     // request address
   logic [xbus_data_w-1:0] datain;   // write data toward the device
   logic                   write;    // read# / write
   logic                   req;      // level, held for the whole cycle
   logic                   timeout;  // single pulse, req already low
   logic [xbus_data_w-1:0] dataout;  // read data, valid at ack
   logic                   ack;      // single pulse from the device
   logic                   decode;   // req with an address in a window

   modport master (
      input  clk,
      output addr,
      output datain,
      output write,
      output req,
      output timeout,
      input  dataout,
      input  ack,
      input  decode
   );

   modport device (
      input  clk,
      input  addr,
      input  datain,
      input  write,
      input  req,
      input  timeout,
      output dataout,
      output ack,
      output decode
   );

endinterface

/* verilog/cmd_fifo.sv */
// pending command queue
module cmd_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  depth     = 4
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t pop_data,
   output logic     empty,
   output logic     full
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   payload_t   mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign do_push = push && !full;   // dropped when full
   assign do_pop  = pop && !empty;

   assign empty    = (count == '0);
   assign full     = (count == cnt_w'(depth));
   assign pop_data = mem[rd_ptr];    // head of queue, read without a clock

   // storage
   always_ff @(posedge clk)
   begin
      if (do_push)
      begin
         mem[wr_ptr] <= push_data;
      end
   end

   // pointers and occupancy
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
         begin
            if (wr_ptr == ptr_w'(depth - 1))
               wr_ptr <= '0;
            else
               wr_ptr <= wr_ptr + 1'b1;
         end

         if (do_pop)
         begin
            if (rd_ptr == ptr_w'(depth - 1))
               rd_ptr <= '0;
            else
               rd_ptr <= rd_ptr + 1'b1;
         end

         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

endmodule

/* verilog/xbus_master.sv */
// xbus bus master
module xbus_master
   import xbus_pkg::*;
#(
   parameter int timeout_cycles = 16
) (
   input  logic                   clk,
   input  logic                   reset,
   input  xbus_req_t              cmd,
   input  logic                   empty,
   output logic                   pop,
   xbus_if.master                 bus,
   output logic                   rsp_valid,
   output logic [xbus_data_w-1:0] rsp_data,
   output logic                   rsp_timeout
);

   localparam int cnt_w = (timeout_cycles > 1) ? $clog2(timeout_cycles) : 1;

   typedef enum logic [1:0] {
      st_idle,
      st_cycle,
      st_respond
   } state_t;

   state_t           state;
   xbus_req_t        cur;        // command on the bus
   logic [cnt_w-1:0] cnt;        // cycles of req so far
   logic             timed_out;
   logic             expired;

   assign pop     = (state == st_idle) && !empty;
   assign expired = (cnt == cnt_w'(timeout_cycles - 1));

   // bus outputs come straight from the held command
   assign bus.addr    = cur.addr;
   assign bus.datain  = cur.data;
   assign bus.write   = cur.write;
   assign bus.req     = (state == st_cycle);
   assign bus.timeout = (state == st_respond) && timed_out;   // req is already low here

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= st_idle;
         cnt         <= '0;
         timed_out   <= 1'b0;
         rsp_valid   <= 1'b0;
         rsp_timeout <= 1'b0;
      end
      else
      begin
         rsp_valid   <= (state == st_respond);
         rsp_timeout <= (state == st_respond) && timed_out;

         case (state)
            st_idle:
            begin
               if (!empty)
               begin
                  state     <= st_cycle;
                  cnt       <= '0;
                  timed_out <= 1'b0;
               end
            end
            st_cycle:
            begin
               if (bus.ack)
                  state <= st_respond;
               else if (expired)
               begin
                  state     <= st_respond;
                  timed_out <= 1'b1;
               end
               else
                  cnt <= cnt + 1'b1;
            end
            default:
               state <= st_idle;   // one response, then back for the next command
         endcase
      end
   end

   // command and response payload
   always_ff @(posedge clk)
   begin
      if (pop)
         cur <= cmd;
      if (state == st_cycle)
      begin
         if (bus.ack)
            rsp_data <= bus.dataout;
         else if (expired)
            rsp_data <= '0;   // nothing answered
      end
   end

endmodule

/* verilog/xbus_unibus.sv */
// unibus register device
module xbus_unibus
   import xbus_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   xbus_if.device bus,
   output logic   promdisable
);

   logic [unibus_win_bits-1:0] offset;
   logic                       in_unibus;
   logic                       in_other;
   logic                       decode_unibus;
   logic                       decode_other;
   logic                       busy;        // set from first decode until ack
   logic                       first;       // first decode cycle of a bus cycle
   logic [1:0]                 ack_dly;
   logic                       unibus_int_en;
   logic                       unibus_nxm;  // timeout in the unibus range
   logic                       xbus_nxm;    // timeout in the xbus range
   logic [xbus_data_w-1:0]     bus_ints;
   logic [xbus_data_w-1:0]     bus_status;

   // address decode
   assign in_unibus = (bus.addr[xbus_addr_w-1:unibus_win_bits]
                       == unibus_base[xbus_addr_w-1:unibus_win_bits]);
   assign in_other  = (bus.addr[xbus_addr_w-1:spy_win_bits]
                       == spy_base[xbus_addr_w-1:spy_win_bits])
                   || (bus.addr[xbus_addr_w-1:lashup_win_bits]
                       == lashup_base[xbus_addr_w-1:lashup_win_bits]);

   assign decode_unibus = bus.req && in_unibus;
   assign decode_other  = bus.req && in_other;   // acked, otherwise ignored
   assign bus.decode    = decode_unibus || decode_other;

   assign offset = bus.addr[unibus_win_bits-1:0];
   assign first  = bus.decode && !busy;
   assign bus.ack = ack_dly[1];

   // readable registers, unused fields read as zero
   always_comb
   begin
      bus_ints                  = '0;
      bus_ints[ints_en_bit]     = unibus_int_en;
      bus_status                = '0;
      bus_status[unibus_nxm_bit] = unibus_nxm;
      bus_status[xbus_nxm_bit]   = xbus_nxm;
   end

   // ack two cycles after the first decode
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack_dly <= '0;
         busy    <= 1'b0;
      end
      else
      begin
         ack_dly <= {ack_dly[0], first};
         if (bus.ack)
            busy <= 1'b0;
         else if (first)
            busy <= 1'b1;
      end
   end

   // write side effects
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         promdisable   <= 1'b0;
         unibus_int_en <= 1'b0;
      end
      else
      begin
         promdisable <= first && in_unibus && bus.write && (offset == reg_prom)
                        && bus.datain[5] && bus.datain[2] && !bus.datain[0];
         if (first && in_unibus && bus.write && (offset == reg_ints))
            unibus_int_en <= bus.datain[ints_en_bit];
      end
   end

   // nxm flags, a timeout beats a clear
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         unibus_nxm <= 1'b0;
         xbus_nxm   <= 1'b0;
      end
      else if (bus.timeout)
      begin
         if (bus.addr > unibus_nxm_floor)
            unibus_nxm <= 1'b1;
         else if (bus.addr > xbus_nxm_floor)
            xbus_nxm <= 1'b1;
      end
      else if (first && in_unibus && bus.write && (offset == reg_status))
      begin
         unibus_nxm <= 1'b0;
         xbus_nxm   <= 1'b0;
      end
   end

   // read data, held until ack
   always_ff @(posedge clk)
   begin
      if (first)
      begin
         if (bus.write || !in_unibus)
            bus.dataout <= '0;
         else if (offset == reg_ints)
            bus.dataout <= bus_ints;
         else if (offset == reg_status)
            bus.dataout <= bus_status;
         else
            bus.dataout <= '0;
      end
   end

endmodule

/* verilog/xbus_top.sv */
// xbus command subsystem
module xbus_top
   import xbus_pkg::*;
#(
   parameter int fifo_depth     = 4,
   parameter int timeout_cycles = 16
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   cmd_valid,
   input  logic [xbus_addr_w-1:0] cmd_addr,
   input  logic [xbus_data_w-1:0] cmd_data,
   input  logic                   cmd_write,
   output logic                   cmd_full,
   output logic                   rsp_valid,
   output logic [xbus_data_w-1:0] rsp_data,
   output logic                   rsp_timeout,
   output logic                   promdisable
);

   xbus_req_t cmd_in;
   xbus_req_t cmd_head;   // oldest queued command
   logic      fifo_empty;
   logic      fifo_pop;

   assign cmd_in = '{addr: cmd_addr, data: cmd_data, write: cmd_write};

   xbus_if bus (.clk(clk));

   cmd_fifo #(
      .payload_t (xbus_req_t),
      .depth     (fifo_depth)
   ) u_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (cmd_valid),
      .push_data (cmd_in),
      .pop       (fifo_pop),
      .pop_data  (cmd_head),
      .empty     (fifo_empty),
      .full      (cmd_full)
   );

   xbus_master #(
      .timeout_cycles (timeout_cycles)
   ) u_master (
      .clk         (clk),
      .reset       (reset),
      .cmd         (cmd_head),
      .empty       (fifo_empty),
      .pop         (fifo_pop),
      .bus         (bus.master),
      .rsp_valid   (rsp_valid),
      .rsp_data    (rsp_data),
      .rsp_timeout (rsp_timeout)
   );

   xbus_unibus u_unibus (
      .clk         (clk),
      .reset       (reset),
      .bus         (bus.device),
      .promdisable (promdisable)
   );

endmodule

/* verif/xbus_chk.sv */
// xbus protocol checks
module xbus_chk (
   input logic clk,
   input logic reset,
   input logic req,
   input logic ack,
   input logic decode,
   input logic timeout,
   input logic rsp_valid,
   input logic cmd_valid
);

   logic decode_d;
   logic first_dec;   // first decode cycle of a bus cycle
   logic pushed;      // a command was pushed since reset

   assign first_dec = decode && !decode_d;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         decode_d <= 1'b0;
         pushed   <= 1'b0;
      end
      else
      begin
         decode_d <= decode;
         if (cmd_valid)
            pushed <= 1'b1;
      end
   end

   ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
      ack |-> req || $past(req))
      else $error("ack seen outside a bus cycle");

   // exactly two cycles from first decode to ack
   ack_delay: assert property (@(posedge clk) disable iff (reset)
      ack == $past(first_dec, 2))
      else $error("ack not two cycles after the first decode");

   timeout_no_ack: assert property (@(posedge clk) disable iff (reset)
      timeout |-> !ack && !$past(ack))
      else $error("timeout and ack in the same bus cycle");

   rsp_single: assert property (@(posedge clk) disable iff (reset)
      rsp_valid |=> !rsp_valid)
      else $error("rsp_valid held longer than one cycle");

   quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
      !pushed |-> !req && !rsp_valid)
      else $error("bus activity before any command was pushed");

endmodule

/* verif/xbus_tb.sv */
// xbus subsystem testbench
module xbus_tb
   import xbus_pkg::*;
();

   typedef struct packed {
      logic [xbus_data_w-1:0] data;
      logic                   timeout;
   } rsp_t;

   logic                   clk;
   logic                   reset;
   logic                   cmd_valid;
   logic [xbus_addr_w-1:0] cmd_addr;
   logic [xbus_data_w-1:0] cmd_data;
   logic                   cmd_write;
   logic                   cmd_full;
   logic                   rsp_valid;
   logic [xbus_data_w-1:0] rsp_data;
   logic                   rsp_timeout;
   logic                   promdisable;

   rsp_t                   exp_q[$];   // expected responses, push order
   rsp_t                   head;
   logic                   model_en;   // interrupt enable as the model sees it
   logic                   model_unxm;
   logic                   model_xnxm;
   int                     exp_prom;   // promdisable pulses expected so far
   int                     prom_pulses;
   int                     burst_n;
   logic [xbus_data_w-1:0] rnd;
   integer                 seed;

   xbus_top dut (.*);

   bind xbus_top xbus_chk chk (
      .clk       (clk),
      .reset     (reset),
      .req       (bus.req),
      .ack       (bus.ack),
      .decode    (bus.decode),
      .timeout   (bus.timeout),
      .rsp_valid (rsp_valid),
      .cmd_valid (cmd_valid)
   );

   always #5 clk = ~clk;

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   function automatic logic in_window(input logic [xbus_addr_w-1:0] a,
                                      input logic [xbus_addr_w-1:0] base, input int size);
      return (a >= base) && (int'(a) < int'(base) + size);
   endfunction

   // expected response and register effects of one command
   task automatic predict(input logic [xbus_addr_w-1:0] addr,
                          input logic [xbus_data_w-1:0] data, input logic write);
      rsp_t r;
      int   off;
      r   = '0;
      off = int'(addr) - int'(unibus_base);
      if (in_window(addr, unibus_base, 64))
      begin
         if (write && off == int'(reg_prom))
         begin
            if (data[5] && data[2] && !data[0])
               exp_prom++;
         end
         else if (write && off == int'(reg_ints))
            model_en = data[ints_en_bit];
         else if (write && off == int'(reg_status))
         begin
            model_unxm = 1'b0;
            model_xnxm = 1'b0;
         end
         else if (!write && off == int'(reg_ints))
            r.data[ints_en_bit] = model_en;
         else if (!write && off == int'(reg_status))
         begin
            r.data[unibus_nxm_bit] = model_unxm;
            r.data[xbus_nxm_bit]   = model_xnxm;
         end
      end
      else if (!in_window(addr, spy_base, 64) && !in_window(addr, lashup_base, 4096))
      begin
         r.timeout = 1'b1;   // nobody decodes it
         if (addr > unibus_nxm_floor)
            model_unxm = 1'b1;
         else if (addr > xbus_nxm_floor)
            model_xnxm = 1'b1;
      end
      exp_q.push_back(r);
   endtask

   // called on a falling edge, returns on the next one
   task automatic push_cmd(input logic [xbus_addr_w-1:0] addr,
                           input logic [xbus_data_w-1:0] data, input logic write);
      int waited;
      waited = 0;
      while (cmd_full)
      begin
         @(negedge clk);
         waited++;
         if (waited > 100)
            stop_with_failure("command queue stayed full too long");
      end
      cmd_valid = 1'b1;
      cmd_addr  = addr;
      cmd_data  = data;
      cmd_write = write;
      predict(addr, data, write);
      @(negedge clk);
      cmd_valid = 1'b0;
   endtask

   task automatic wait_for_responses;
      int waited;
      waited = 0;
      while (exp_q.size() != 0)
      begin
         @(negedge clk);
         waited++;
         if (waited > 400)
            stop_with_failure("responses still missing after waiting");
      end
   endtask

   task automatic write_prom(input logic [xbus_data_w-1:0] data);
      push_cmd(unibus_base + reg_prom, data, 1'b1);
      wait_for_responses();
      assert (prom_pulses == exp_prom)
      else
         stop_with_failure($sformatf("Fail %0t promdisable pulses got %0d expected %0d",
                                     $time, prom_pulses, exp_prom));
   endtask

   // outputs sampled away from the rising edge
   always @(negedge clk)
   begin
      if (!reset && promdisable)
         prom_pulses++;
      if (!reset && rsp_valid)
      begin
         if (exp_q.size() == 0)
            stop_with_failure("response arrived with no command outstanding");
         head = exp_q.pop_front();
         assert (rsp_timeout == head.timeout)
         else
            stop_with_failure($sformatf("Fail %0t rsp_timeout got %b expected %b",
                                        $time, rsp_timeout, head.timeout));
         assert (rsp_data == head.data)
         else
            stop_with_failure($sformatf("Fail %0t rsp_data got %h expected %h",
                                        $time, rsp_data, head.data));
      end
   end

   initial
   begin
      clk         = 1'b0;
      reset       = 1'b1;
      cmd_valid   = 1'b0;
      cmd_addr    = '0;
      cmd_data    = '0;
      cmd_write   = 1'b0;
      model_en    = 1'b0;
      model_unxm  = 1'b0;
      model_xnxm  = 1'b0;
      exp_prom    = 0;
      prom_pulses = 0;
      seed        = 32'h236b;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // interrupt enable set, then cleared
      rnd = $random(seed);
      push_cmd(unibus_base + reg_ints, rnd | (32'd1 << ints_en_bit), 1'b1);
      push_cmd(unibus_base + reg_ints, '0, 1'b0);
      push_cmd(unibus_base + reg_ints, rnd & ~(32'd1 << ints_en_bit), 1'b1);
      push_cmd(unibus_base + reg_ints, '0, 1'b0);
      wait_for_responses();

      push_cmd(22'o17500000, '0, 1'b0);   // unibus nxm range
      push_cmd(22'o17200000, rnd, 1'b1);  // xbus nxm range
      push_cmd(unibus_base + reg_status, '0, 1'b0);
      wait_for_responses();

      // other windows answer with zero and leave the registers alone
      push_cmd(spy_base + 22'o3, '0, 1'b0);
      push_cmd(lashup_base + 22'o1234, '0, 1'b0);
      push_cmd(spy_base + 22'o22, '0, 1'b1);
      push_cmd(lashup_base + 22'o20, 32'd1 << ints_en_bit, 1'b1);
      push_cmd(unibus_base + reg_status, '0, 1'b0);
      push_cmd(unibus_base + reg_ints, '0, 1'b0);
      push_cmd(unibus_base + reg_status, rnd, 1'b1);
      push_cmd(unibus_base + reg_status, '0, 1'b0);
      wait_for_responses();

      write_prom(32'h24);
      write_prom(32'h25);
      repeat (8)
      begin
         rnd = $random(seed);
         write_prom(rnd);
      end

      // back to back until the queue pushes back
      burst_n = 0;
      while (!cmd_full && burst_n < 16)
      begin
         rnd = $random(seed);
         case (burst_n % 4)
            0: push_cmd(unibus_base + reg_ints, rnd, 1'b1);
            1: push_cmd(unibus_base + reg_ints, '0, 1'b0);
            2: push_cmd(spy_base + rnd[5:0], '0, 1'b0);
            default: push_cmd(unibus_base + reg_status, '0, 1'b0);
         endcase
         burst_n++;
      end
      if (!cmd_full)
         stop_with_failure("burst never filled the command queue");
      wait_for_responses();

      if (prom_pulses == exp_prom)
      begin
         $display("RESULT: PASS");
         $finish;
      end
      else
         stop_with_failure($sformatf("Fail %0t promdisable pulses got %0d expected %0d",
                                     $time, prom_pulses, exp_prom));
   end

endmodule

/* sim.f */
verilog/xbus_pkg.sv
verilog/xbus_if.sv
verilog/cmd_fifo.sv
verilog/xbus_master.sv
verilog/xbus_unibus.sv
verilog/xbus_top.sv
verif/xbus_chk.sv
verif/xbus_tb.sv

/* run.sh */
#!/bin/bash
# build the xbus testbench with Verilator and run it
verilator --binary --timing --assert -Wno-fatal --top-module xbus_tb -f sim.f -o xbus_sim \
   && ./obj_dir/xbus_sim \
   && echo "simulation finished without errors" \
   || { echo "simulation failed"; exit 1; }
